//--- design/bp_pkg.sv
package bp_pkg;

  // ==========================================================
  // Widths
  // ==========================================================
  // Address and data width
  localparam int unsigned XLEN = 32;
  // Tag holds the whole word address above the index
  localparam int unsigned TAG_W = XLEN - 2;

  // ==========================================================
  // Encodings
  // ==========================================================
  localparam logic [6:0] OPC_JAL  = 7'b1101111;
  localparam logic [6:0] OPC_JALR = 7'b1100111;

  // Link registers ra and t0
  localparam logic [4:0] LINK_RA = 5'd1;
  localparam logic [4:0] LINK_T0 = 5'd5;

  // 32-bit view of an instruction word
  typedef struct packed {
    logic [11:0] upper;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } instr32_t;

  // Compressed view, low parcel only
  typedef struct packed {
    logic [15:0] upper;
    logic [3:0]  funct4;
    logic [4:0]  rs1_rd;
    logic [4:0]  rs2;
    logic [1:0]  op;
  } cparcel_t;

  // Same fetched word, two decodes
  typedef union packed {
    instr32_t i32;
    cparcel_t c16;
  } instr_word_u;

  // One BTB entry
  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
    logic [XLEN-1:0]  target;
    logic             taken;
  } btb_entry_t;

  // Tag of a PC for a table with idx_w index bits
  function automatic logic [TAG_W-1:0] btb_tag(input logic [XLEN-1:0] pc,
                                               input int unsigned idx_w);
    return TAG_W'(pc >> (idx_w + 2));
  endfunction

endpackage

//--- design/btb_write_if.sv
interface btb_write_if #(
  parameter int unsigned IDX_W = 4
);

  // One table write per cycle with wr_en high
  logic                     wr_en;
  logic [IDX_W-1:0]         wr_index;
  logic [bp_pkg::TAG_W-1:0] wr_tag;
  logic [bp_pkg::XLEN-1:0]  wr_target;
  logic                     wr_taken;

  // Update FSM side
  modport fsm (
    output wr_en, wr_index, wr_tag, wr_target, wr_taken
  );

  // BTB storage side
  modport tbl (
    input wr_en, wr_index, wr_tag, wr_target, wr_taken
  );

endinterface

//--- design/ras_ctrl_if.sv
interface ras_ctrl_if #(
  parameter int unsigned PTR_W = 3
);

  logic             push;
  logic             pop;
  logic             empty;
  // Top entry, and slot for the next push
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;

  // Prediction gating side
  modport select (
    output push, pop,
    input  empty
  );

  // Pointer and fill counter
  modport pointer (
    input  push, pop,
    output empty, rd_ptr, wr_ptr
  );

  // Return address storage
  modport stack (
    input push, wr_ptr, rd_ptr
  );

endinterface

//--- design/btb_update_fsm.sv
module btb_update_fsm #(
  parameter int unsigned BTB_ENTRIES = 16
) (
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  logic                    i_update_req,
  input  logic [bp_pkg::XLEN-1:0] i_update_pc,
  input  logic [bp_pkg::XLEN-1:0] i_update_target,
  input  logic                    i_update_taken,
  output logic                    o_update_ack,
  btb_write_if.fsm                btb_wr
);

  localparam int unsigned IDX_W = $clog2(BTB_ENTRIES);

  // Handshake states
  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_WRITE = 2'd1;
  localparam logic [1:0] ST_ACK   = 2'd2;
  localparam logic [1:0] ST_WAIT  = 2'd3;

  logic [1:0] state_q;
  logic [1:0] state_d;

  // ==========================================================
  // Four-phase sequencing
  // ==========================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      // Request seen, write goes out next cycle
      ST_IDLE:  if (i_update_req) state_d = ST_WRITE;
      // Single write cycle
      ST_WRITE: state_d = ST_ACK;
      // First ack cycle
      ST_ACK:   state_d = ST_WAIT;
      // Hold ack until the requester lets go
      ST_WAIT:  if (!i_update_req) state_d = ST_IDLE;
      default:  state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign o_update_ack = (state_q == ST_ACK) || (state_q == ST_WAIT);

  // ==========================================================
  // Table write
  // ==========================================================
  // Update fields stay stable while req is high
  assign btb_wr.wr_en     = (state_q == ST_WRITE);
  // Word index, halfword bits dropped
  assign btb_wr.wr_index  = i_update_pc[IDX_W+1:2];
  assign btb_wr.wr_tag    = bp_pkg::btb_tag(i_update_pc, IDX_W);
  assign btb_wr.wr_target = i_update_target;
  assign btb_wr.wr_taken  = i_update_taken;

endmodule

//--- design/btb_table.sv
module btb_table #(
  parameter int unsigned BTB_ENTRIES = 16
) (
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  logic [bp_pkg::XLEN-1:0] i_pc,
  btb_write_if.tbl                btb_wr,
  output logic                    o_hit,
  output logic                    o_taken,
  output logic [bp_pkg::XLEN-1:0] o_target
);

  localparam int unsigned IDX_W = $clog2(BTB_ENTRIES);

  bp_pkg::btb_entry_t entries_q [BTB_ENTRIES];

  logic [IDX_W-1:0]   rd_index;
  bp_pkg::btb_entry_t rd_entry;

  // ==========================================================
  // Storage
  // ==========================================================
  // Reset only invalidates, payload stays
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 0; i < BTB_ENTRIES; i++) begin
        entries_q[i].valid <= 1'b0;
      end
    end else if (btb_wr.wr_en) begin
      // Taken bit follows the last resolved outcome
      entries_q[btb_wr.wr_index] <= '{
        valid:  1'b1,
        tag:    btb_wr.wr_tag,
        target: btb_wr.wr_target,
        taken:  btb_wr.wr_taken
      };
    end
  end

  // ==========================================================
  // Lookup
  // ==========================================================
  // Same index split as the update side
  assign rd_index = i_pc[IDX_W+1:2];
  assign rd_entry = entries_q[rd_index];

  // Hit needs a valid entry and a matching tag
  assign o_hit    = rd_entry.valid && (rd_entry.tag == bp_pkg::btb_tag(i_pc, IDX_W));
  assign o_taken  = o_hit && rd_entry.taken;
  assign o_target = rd_entry.target;

endmodule

//--- design/ras_detector.sv
module ras_detector (
  input  bp_pkg::instr_word_u i_instruction,
  input  logic                i_is_compressed,
  input  logic                i_instruction_valid,
  output logic                o_is_call,
  output logic                o_is_return
);

  logic call32;
  logic ret32;
  logic c_jal;
  logic c_jr;
  logic c_jalr;

  // ra or t0
  function automatic logic is_link(input logic [4:0] r);
    return (r == bp_pkg::LINK_RA) || (r == bp_pkg::LINK_T0);
  endfunction

  // ==========================================================
  // 32-bit view
  // ==========================================================
  // JAL or JALR writing a link register
  // JALR with rd and rs1 both links counts as call only
  assign call32 = ((i_instruction.i32.opcode == bp_pkg::OPC_JAL) ||
                   (i_instruction.i32.opcode == bp_pkg::OPC_JALR)) &&
                  is_link(i_instruction.i32.rd);

  // JALR x0, link
  assign ret32 = (i_instruction.i32.opcode == bp_pkg::OPC_JALR) &&
                 (i_instruction.i32.rd == 5'd0) &&
                 is_link(i_instruction.i32.rs1);

  // ==========================================================
  // Compressed view
  // ==========================================================
  // C.JAL, quadrant 1 with funct3 001
  assign c_jal = (i_instruction.c16.op == 2'b01) &&
                 (i_instruction.c16.funct4[3:1] == 3'b001);

  // C.JR, rs2 zero, link source
  assign c_jr = (i_instruction.c16.op == 2'b10) &&
                (i_instruction.c16.funct4 == 4'b1000) &&
                (i_instruction.c16.rs2 == 5'd0) &&
                is_link(i_instruction.c16.rs1_rd);

  // C.JALR always links through ra; rs1 zero would be C.EBREAK
  assign c_jalr = (i_instruction.c16.op == 2'b10) &&
                  (i_instruction.c16.funct4 == 4'b1001) &&
                  (i_instruction.c16.rs2 == 5'd0) &&
                  (i_instruction.c16.rs1_rd != 5'd0);

  assign o_is_call   = i_instruction_valid && (i_is_compressed ? (c_jal || c_jalr) : call32);
  assign o_is_return = i_instruction_valid && (i_is_compressed ? c_jr : ret32);

endmodule

//--- design/ras_pointer.sv
module ras_pointer #(
  parameter int unsigned RAS_DEPTH = 8
) (
  input  logic        i_clk,
  input  logic        i_reset,
  input  logic        i_stall,
  ras_ctrl_if.pointer ras_ctrl
);

  localparam int unsigned PTR_W = $clog2(RAS_DEPTH);
  localparam int unsigned CNT_W = $clog2(RAS_DEPTH + 1);

  logic [PTR_W-1:0] tos_q;
  logic [PTR_W-1:0] tos_next;
  logic [PTR_W-1:0] tos_prev;
  logic [CNT_W-1:0] count_q;
  logic             full;

  // Circular neighbours of the top, any depth
  assign tos_next = (tos_q == PTR_W'(RAS_DEPTH - 1)) ? '0 : tos_q + PTR_W'(1);
  assign tos_prev = (tos_q == '0) ? PTR_W'(RAS_DEPTH - 1) : tos_q - PTR_W'(1);

  assign full = (count_q == CNT_W'(RAS_DEPTH));

  // ==========================================================
  // Top pointer and fill count
  // ==========================================================
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      tos_q   <= '0;
      count_q <= '0;
    end else if (!i_stall) begin
      if (ras_ctrl.push) begin
        // Full stack wraps over the oldest entry
        tos_q <= tos_next;
        if (!full) begin
          count_q <= count_q + CNT_W'(1);
        end
      end else if (ras_ctrl.pop && !ras_ctrl.empty) begin
        tos_q   <= tos_prev;
        count_q <= count_q - CNT_W'(1);
      end
    end
  end

  assign ras_ctrl.empty  = (count_q == '0);
  assign ras_ctrl.rd_ptr = tos_q;
  // Push lands one slot above the top
  assign ras_ctrl.wr_ptr = tos_next;

endmodule

//--- design/ras_stack.sv
module ras_stack #(
  parameter int unsigned RAS_DEPTH = 8
) (
  input  logic                    i_clk,
  input  logic [bp_pkg::XLEN-1:0] i_link_address,
  ras_ctrl_if.stack               ras_ctrl,
  output logic [bp_pkg::XLEN-1:0] o_top_target
);

  // Return addresses, no reset
  logic [bp_pkg::XLEN-1:0] stack_q [RAS_DEPTH];

  // Push stores the link address in the next slot
  always_ff @(posedge i_clk) begin
    if (ras_ctrl.push) begin
      stack_q[ras_ctrl.wr_ptr] <= i_link_address;
    end
  end

  // Top entry, read combinationally
  // Meaningful only while the fill count is nonzero
  assign o_top_target = stack_q[ras_ctrl.rd_ptr];

endmodule

//--- design/prediction_select.sv
module prediction_select (
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  logic                    i_stall,
  input  logic                    i_redirect,
  input  logic [bp_pkg::XLEN-1:0] i_pc,
  input  logic                    i_is_compressed,
  input  logic                    i_instruction_valid,
  input  logic                    i_btb_hit,
  input  logic                    i_btb_taken,
  input  logic [bp_pkg::XLEN-1:0] i_btb_target,
  input  logic                    i_is_call,
  input  logic                    i_is_return,
  input  logic [bp_pkg::XLEN-1:0] i_ras_target,
  ras_ctrl_if.select              ras_ctrl,
  output logic                    o_prediction_used,
  output logic [bp_pkg::XLEN-1:0] o_predicted_target,
  output logic                    o_ras_predicted,
  output logic                    o_prediction_used_r,
  output logic [bp_pkg::XLEN-1:0] o_predicted_target_r,
  output logic                    o_prediction_holdoff,
  output logic                    o_btb_only_holdoff
);

  logic allowed;
  logic sel_btb;
  logic sel_ras;
  logic btb_only;

  // ==========================================================
  // Gating
  // ==========================================================
  // Holdoff blocks a second prediction on stale fetch data
  assign allowed = !i_stall && !i_redirect && !o_prediction_holdoff;

  // BTB sees only the PC, so halfword PCs are never trusted
  assign sel_btb = allowed && !i_pc[1] && i_btb_hit && i_btb_taken;

  // RAS knows the instruction, compressed returns may sit on a halfword
  assign sel_ras = allowed && i_is_return && !ras_ctrl.empty &&
                   (!i_pc[1] || i_is_compressed);

  assign btb_only = sel_btb && !sel_ras;

  assign o_prediction_used = sel_btb || sel_ras;
  assign o_ras_predicted   = sel_ras;

  // RAS wins over BTB; zero when nothing predicted
  always_comb begin
    if (sel_ras) begin
      o_predicted_target = i_ras_target;
    end else if (sel_btb) begin
      o_predicted_target = i_btb_target;
    end else begin
      o_predicted_target = '0;
    end
  end

  // ==========================================================
  // RAS control
  // ==========================================================
  // After a BTB-only prediction the fetched call is real, so it may push
  assign ras_ctrl.push = i_instruction_valid && i_is_call && !i_stall &&
                         (!o_prediction_holdoff || o_btb_only_holdoff);
  assign ras_ctrl.pop  = sel_ras;

  // ==========================================================
  // Registered metadata and holdoffs
  // ==========================================================
  // Metadata travels with the instruction to the next stage
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_prediction_used_r  <= 1'b0;
      o_predicted_target_r <= '0;
    end else if (!i_stall) begin
      o_prediction_used_r  <= o_prediction_used;
      o_predicted_target_r <= o_predicted_target;
    end
  end

  // One cycle after a used prediction; redirect clears even under stall
  always_ff @(posedge i_clk) begin
    if (i_reset || i_redirect) begin
      o_prediction_holdoff <= 1'b0;
      o_btb_only_holdoff   <= 1'b0;
    end else if (!i_stall) begin
      o_prediction_holdoff <= o_prediction_used;
      o_btb_only_holdoff   <= btb_only;
    end
  end

endmodule

//--- design/branch_predict_top.sv
module branch_predict_top #(
  parameter int unsigned BTB_ENTRIES = 16,
  parameter int unsigned RAS_DEPTH   = 8
) (
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  logic                    i_stall,
  // Trap, mret or resolved branch
  input  logic                    i_redirect,
  // Fetch side
  input  logic [bp_pkg::XLEN-1:0] i_pc,
  input  logic [bp_pkg::XLEN-1:0] i_instruction,
  input  logic                    i_is_compressed,
  input  logic                    i_instruction_valid,
  input  logic [bp_pkg::XLEN-1:0] i_link_address,
  // Execute-stage update handshake
  input  logic                    i_update_req,
  input  logic [bp_pkg::XLEN-1:0] i_update_pc,
  input  logic [bp_pkg::XLEN-1:0] i_update_target,
  input  logic                    i_update_taken,
  output logic                    o_update_ack,
  // Predictions
  output logic                    o_prediction_used,
  output logic [bp_pkg::XLEN-1:0] o_predicted_target,
  output logic                    o_ras_predicted,
  output logic                    o_prediction_used_r,
  output logic [bp_pkg::XLEN-1:0] o_predicted_target_r,
  output logic                    o_prediction_holdoff,
  output logic                    o_btb_only_holdoff
);

  localparam int unsigned BTB_IDX_W = $clog2(BTB_ENTRIES);
  localparam int unsigned RAS_PTR_W = $clog2(RAS_DEPTH);

  bp_pkg::instr_word_u     instr_word;
  logic                    btb_hit;
  logic                    btb_taken;
  logic [bp_pkg::XLEN-1:0] btb_target;
  logic                    is_call;
  logic                    is_return;
  logic [bp_pkg::XLEN-1:0] ras_target;

  btb_write_if #(.IDX_W(BTB_IDX_W)) btb_wr ();
  ras_ctrl_if #(.PTR_W(RAS_PTR_W)) ras_ctrl ();

  // Raw fetch word seen through both decodes
  assign instr_word = i_instruction;

  // ==========================================================
  // BTB
  // ==========================================================
  btb_update_fsm #(.BTB_ENTRIES(BTB_ENTRIES)) i_btb_update_fsm (
    .i_clk, .i_reset, .i_update_req, .i_update_pc, .i_update_target,
    .i_update_taken, .o_update_ack, .btb_wr(btb_wr.fsm)
  );

  btb_table #(.BTB_ENTRIES(BTB_ENTRIES)) i_btb_table (
    .i_clk, .i_reset, .i_pc, .btb_wr(btb_wr.tbl),
    .o_hit(btb_hit), .o_taken(btb_taken), .o_target(btb_target)
  );

  // ==========================================================
  // RAS
  // ==========================================================
  ras_detector i_ras_detector (
    .i_instruction(instr_word), .i_is_compressed, .i_instruction_valid,
    .o_is_call(is_call), .o_is_return(is_return)
  );

  ras_pointer #(.RAS_DEPTH(RAS_DEPTH)) i_ras_pointer (
    .i_clk, .i_reset, .i_stall, .ras_ctrl(ras_ctrl.pointer)
  );

  ras_stack #(.RAS_DEPTH(RAS_DEPTH)) i_ras_stack (
    .i_clk, .i_link_address, .ras_ctrl(ras_ctrl.stack), .o_top_target(ras_target)
  );

  // Gating and output flops
  prediction_select i_prediction_select (
    .i_clk, .i_reset, .i_stall, .i_redirect, .i_pc, .i_is_compressed,
    .i_instruction_valid, .i_btb_hit(btb_hit), .i_btb_taken(btb_taken),
    .i_btb_target(btb_target), .i_is_call(is_call), .i_is_return(is_return),
    .i_ras_target(ras_target), .ras_ctrl(ras_ctrl.select),
    .o_prediction_used, .o_predicted_target, .o_ras_predicted,
    .o_prediction_used_r, .o_predicted_target_r, .o_prediction_holdoff,
    .o_btb_only_holdoff
  );

endmodule

//--- tb/branch_predict_props.sv
module branch_predict_props (
  input logic        i_clk,
  input logic        i_reset,
  input logic        i_stall,
  input logic        i_update_req,
  input logic        o_update_ack,
  input logic        o_prediction_used,
  input logic [31:0] o_predicted_target,
  input logic        o_prediction_used_r,
  input logic [31:0] o_predicted_target_r,
  input logic        o_prediction_holdoff
);
  timeunit 1ns;
  timeprecision 1ps;

  // Count of failed assertions
  int assert_failures = 0;

  // ==========================================================
  // Update handshake
  // ==========================================================
  // Ack answers a live request only
  ack_rise_needs_req: assert property (@(posedge i_clk) disable iff (i_reset)
    $rose(o_update_ack) |-> i_update_req)
    else begin
      assert_failures++;
      $error("update ack rose while req was low");
    end

  // Ack drops only once the requester has let go
  ack_fall_after_req_low: assert property (@(posedge i_clk) disable iff (i_reset)
    $fell(o_update_ack) |-> $past(!i_update_req))
    else begin
      assert_failures++;
      $error("update ack fell while req was still high");
    end

  // ==========================================================
  // Prediction outputs
  // ==========================================================
  // No back-to-back predictions
  holdoff_blocks_prediction: assert property (@(posedge i_clk) disable iff (i_reset)
    o_prediction_holdoff |-> !o_prediction_used)
    else begin
      assert_failures++;
      $error("prediction used while holdoff was high");
    end

  // Metadata flops follow the combinational outputs when not stalled
  registered_follow: assert property (@(posedge i_clk) disable iff (i_reset)
    $past(!i_stall && !i_reset) |->
      (o_prediction_used_r == $past(o_prediction_used)) &&
      (o_predicted_target_r == $past(o_predicted_target)))
    else begin
      assert_failures++;
      $error("registered prediction differs from previous cycle");
    end

endmodule

//--- tb/tb_branch_predict.sv
module tb_branch_predict;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned BTB_ENTRIES = 16;
  localparam int unsigned RAS_DEPTH   = 8;
  // 8 tests of at most 400 cycles each plus margin
  localparam int unsigned TIMEOUT     = 4000;
  // Never trained so fetches here never hit
  localparam logic [31:0] IDLE_PC     = 32'h0000_0f00;
  localparam logic [31:0] NOP         = 32'h0000_0013;
  localparam logic [31:0] RET_RA      = {12'h0, 5'd1, 3'b000, 5'd0, 7'b1100111};

  logic        i_clk;
  logic        i_reset;
  logic        i_stall;
  logic        i_redirect;
  logic [31:0] i_pc;
  logic [31:0] i_instruction;
  logic        i_is_compressed;
  logic        i_instruction_valid;
  logic [31:0] i_link_address;
  logic        i_update_req;
  logic [31:0] i_update_pc;
  logic [31:0] i_update_target;
  logic        i_update_taken;
  logic        o_update_ack;
  logic        o_prediction_used;
  logic [31:0] o_predicted_target;
  logic        o_ras_predicted;
  logic        o_prediction_used_r;
  logic [31:0] o_predicted_target_r;
  logic        o_prediction_holdoff;
  logic        o_btb_only_holdoff;

  // ==========================================================
  // Reference model
  // ==========================================================
  // BTB entries keep the whole word address instead of a tag
  logic        m_valid  [BTB_ENTRIES];
  logic [29:0] m_word   [BTB_ENTRIES];
  logic [31:0] m_target [BTB_ENTRIES];
  logic        m_taken  [BTB_ENTRIES];
  // Newest return address at the back
  logic [31:0] m_ras [$];
  logic        m_hold;
  logic        m_bhold;

  string       test_name;
  int          errors;
  int          test_errors;
  int          checks;
  int          tests;
  int unsigned cycle_count;
  logic [31:0] probe_pc;
  logic [31:0] rand_pc [$];

  branch_predict_top #(
    .BTB_ENTRIES(BTB_ENTRIES),
    .RAS_DEPTH(RAS_DEPTH)
  ) i_branch_predict_top (.*);

  bind branch_predict_top branch_predict_props i_props (.*);

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  // Watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT) begin
      @(posedge i_clk);
      cycle_count++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT);
    $display("Something failed");
    $finish;
  end

  // Instruction encodings
  function automatic logic [31:0] jal_word(input logic [4:0] rd);
    return {20'h0, rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] jalr_word(input logic [4:0] rd, input logic [4:0] rs1);
    return {12'h0, rs1, 3'b000, rd, 7'b1100111};
  endfunction

  // C.JAL in quadrant 1 with funct3 001
  function automatic logic [31:0] c_jal_word();
    return 32'h0000_2001;
  endfunction

  function automatic logic [31:0] c_jalr_word(input logic [4:0] rs1);
    return {16'h0, 4'b1001, rs1, 5'd0, 2'b10};
  endfunction

  function automatic logic [31:0] c_jr_word(input logic [4:0] rs1);
    return {16'h0, 4'b1000, rs1, 5'd0, 2'b10};
  endfunction

  // Taken entry with a matching word address
  function automatic logic predicts_from_btb(input logic [31:0] pc);
    int unsigned idx;
    idx = (pc >> 2) % BTB_ENTRIES;
    return m_valid[idx] && m_taken[idx] && (m_word[idx] == pc[31:2]);
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (expected === actual) else begin
      $display("[ERROR] %s: %s expected %h actual %h", test_name, what, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  // ==========================================================
  // Fetch cycle with model update
  // ==========================================================
  task automatic fetch(input logic [31:0] pc, input logic [31:0] instr, input logic comp,
                       input logic valid, input logic call, input logic ret,
                       input logic [31:0] link, input logic stall, input logic redirect);
    logic        allowed;
    logic        e_btb;
    logic        e_ras;
    logic        e_used;
    logic        push;
    logic [31:0] e_target;
    int unsigned idx;
    @(posedge i_clk);
    i_pc                <= pc;
    i_instruction       <= instr;
    i_is_compressed     <= comp;
    i_instruction_valid <= valid;
    i_link_address      <= link;
    i_stall             <= stall;
    i_redirect          <= redirect;
    @(negedge i_clk);
    idx     = (pc >> 2) % BTB_ENTRIES;
    allowed = !stall && !redirect && !m_hold;
    e_btb   = allowed && !pc[1] && predicts_from_btb(pc);
    // Halfword PC is fine for a compressed return
    e_ras   = allowed && valid && ret && (m_ras.size() != 0) && (!pc[1] || comp);
    e_used  = e_btb || e_ras;
    // RAS wins
    if (e_ras) begin
      e_target = m_ras[$];
    end else begin
      e_target = m_target[idx];
    end
    check_value("holdoff", m_hold, o_prediction_holdoff);
    check_value("btb_only_holdoff", m_bhold, o_btb_only_holdoff);
    check_value("prediction_used", e_used, o_prediction_used);
    check_value("ras_predicted", e_ras, o_ras_predicted);
    if (e_used) begin
      check_value("predicted_target", e_target, o_predicted_target);
    end
    // State after the coming edge
    push = valid && call && !stall && (!m_hold || m_bhold);
    if (push) begin
      m_ras.push_back(link);
      // Full stack drops the oldest
      if (m_ras.size() > RAS_DEPTH) begin
        void'(m_ras.pop_front());
      end
    end else if (e_ras) begin
      void'(m_ras.pop_back());
    end
    if (redirect) begin
      m_hold  = 1'b0;
      m_bhold = 1'b0;
    end else if (!stall) begin
      m_hold  = e_used;
      m_bhold = e_btb && !e_ras;
    end
  endtask

  task automatic idle_cycle();
    fetch(IDLE_PC, NOP, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
  endtask

  task automatic plain_fetch(input logic [31:0] pc);
    fetch(pc, NOP, 1'b0, 1'b1, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0);
  endtask

  task automatic call_fetch(input logic [31:0] pc, input logic [31:0] instr,
                            input logic comp, input logic [31:0] link);
    fetch(pc, instr, comp, 1'b1, 1'b1, 1'b0, link, 1'b0, 1'b0);
  endtask

  task automatic return_fetch(input logic [31:0] pc, input logic [31:0] instr,
                              input logic comp);
    fetch(pc, instr, comp, 1'b1, 1'b0, 1'b1, 32'h0, 1'b0, 1'b0);
  endtask

  // ==========================================================
  // Execute-stage update, four-phase
  // ==========================================================
  // Fetch stays stalled so the prediction state holds still
  task automatic train_btb(input logic [31:0] pc, input logic [31:0] target,
                           input logic taken, input int unsigned pre_gap,
                           input int unsigned post_gap);
    int unsigned idx;
    @(posedge i_clk);
    i_stall             <= 1'b1;
    i_redirect          <= 1'b0;
    i_instruction_valid <= 1'b0;
    i_pc                <= IDLE_PC;
    repeat (pre_gap) @(posedge i_clk);
    @(negedge i_clk);
    check_value("ack before req", 1'b0, o_update_ack);
    @(posedge i_clk);
    i_update_req    <= 1'b1;
    i_update_pc     <= pc;
    i_update_target <= target;
    i_update_taken  <= taken;
    @(negedge i_clk);
    while (!o_update_ack) @(negedge i_clk);
    // Write is in the table once ack is up
    idx           = (pc >> 2) % BTB_ENTRIES;
    m_valid[idx]  = 1'b1;
    m_word[idx]   = pc[31:2];
    m_target[idx] = target;
    m_taken[idx]  = taken;
    repeat (post_gap) @(posedge i_clk);
    @(posedge i_clk);
    i_update_req    <= 1'b0;
    // Changed fields expose a late second write
    i_update_target <= ~target;
    i_update_taken  <= !taken;
    @(negedge i_clk);
    while (o_update_ack) @(negedge i_clk);
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests++;
    $display("test %-16s %s, %0d errors", test_name,
             (test_errors == 0) ? "passed" : "FAILED", test_errors);
  endtask

  // ==========================================================
  // Test sequence
  // ==========================================================
  initial begin
    void'($urandom(32'hc2a5b1bd));
    errors              = 0;
    checks              = 0;
    tests               = 0;
    i_reset             = 1'b1;
    i_stall             = 1'b0;
    i_redirect          = 1'b0;
    i_pc                = IDLE_PC;
    i_instruction       = NOP;
    i_is_compressed     = 1'b0;
    i_instruction_valid = 1'b0;
    i_link_address      = 32'h0;
    i_update_req        = 1'b0;
    i_update_pc         = 32'h0;
    i_update_target     = 32'h0;
    i_update_taken      = 1'b0;
    for (int i = 0; i < BTB_ENTRIES; i++) begin
      m_valid[i]  = 1'b0;
      m_word[i]   = '0;
      m_target[i] = '0;
      m_taken[i]  = 1'b0;
    end
    m_hold  = 1'b0;
    m_bhold = 1'b0;
    repeat (4) @(posedge i_clk);
    i_reset <= 1'b0;

    // Trained PC predicts, untrained does not
    start_test("training");
    train_btb(32'h8000_0040, 32'h8000_1000, 1'b1, 0, 0);
    plain_fetch(32'h8000_0040);
    idle_cycle();
    plain_fetch(32'h8000_0080);
    idle_cycle();
    end_test();

    start_test("not_taken");
    train_btb(32'h8000_0040, 32'h8000_1000, 1'b0, 1, 1);
    plain_fetch(32'h8000_0040);
    idle_cycle();
    end_test();

    // Aliasing indices overwrite each other
    start_test("random_updates");
    for (int i = 0; i < 24; i++) begin
      probe_pc = 32'h8000_0000 | ($urandom & 32'h0000_03fc);
      rand_pc.push_back(probe_pc);
      train_btb(probe_pc, $urandom & 32'hffff_fffc, 1'($urandom), 0, 0);
    end
    foreach (rand_pc[i]) begin
      plain_fetch(rand_pc[i]);
      idle_cycle();
    end
    end_test();

    // Mixed encodings popped in LIFO order
    start_test("call_return");
    call_fetch(32'h0000_2000, jal_word(5'd1), 1'b0, 32'h0000_2004);
    call_fetch(32'h0000_2100, c_jal_word(), 1'b1, 32'h0000_2102);
    call_fetch(32'h0000_2200, jalr_word(5'd5, 5'd6), 1'b0, 32'h0000_2204);
    call_fetch(32'h0000_2300, c_jalr_word(5'd6), 1'b1, 32'h0000_2302);
    return_fetch(32'h0000_3000, RET_RA, 1'b0);
    idle_cycle();
    return_fetch(32'h0000_3102, c_jr_word(5'd1), 1'b1);
    idle_cycle();
    return_fetch(32'h0000_3200, jalr_word(5'd0, 5'd5), 1'b0);
    idle_cycle();
    return_fetch(32'h0000_3300, c_jr_word(5'd5), 1'b1);
    idle_cycle();
    // Stack is empty now
    return_fetch(32'h0000_3400, RET_RA, 1'b0);
    idle_cycle();
    end_test();

    start_test("ras_overflow");
    for (int i = 0; i < RAS_DEPTH + 3; i++) begin
      call_fetch(32'h0000_2000 + 8 * i, jal_word(5'd1), 1'b0, 32'h0000_5000 + 4 * i);
    end
    for (int i = 0; i < RAS_DEPTH + 1; i++) begin
      return_fetch(32'h0000_3000, RET_RA, 1'b0);
      idle_cycle();
    end
    end_test();

    start_test("priority_holdoff");
    train_btb(32'h8000_0200, 32'h8000_2000, 1'b1, 0, 0);
    call_fetch(32'h0000_2000, jal_word(5'd1), 1'b0, 32'h0000_2004);
    // Return on a trained PC gives the RAS target
    return_fetch(32'h8000_0200, RET_RA, 1'b0);
    plain_fetch(32'h8000_0200);
    idle_cycle();
    // BTB alone and then a call under the BTB-only holdoff
    plain_fetch(32'h8000_0200);
    call_fetch(32'h0000_2010, jal_word(5'd1), 1'b0, 32'h0000_2014);
    idle_cycle();
    return_fetch(32'h0000_3000, RET_RA, 1'b0);
    idle_cycle();
    end_test();

    start_test("gating");
    call_fetch(32'h0000_2000, jal_word(5'd1), 1'b0, 32'h0000_2004);
    fetch(32'h0000_3000, RET_RA, 1'b0, 1'b1, 1'b0, 1'b1, 32'h0, 1'b1, 1'b0);
    fetch(32'h0000_3000, RET_RA, 1'b0, 1'b1, 1'b0, 1'b1, 32'h0, 1'b0, 1'b1);
    // Halfword PC in a trained word
    plain_fetch(32'h8000_0202);
    return_fetch(32'h0000_3002, RET_RA, 1'b0);
    return_fetch(32'h0000_3002, c_jr_word(5'd1), 1'b1);
    // Redirect clears the holdoff
    fetch(IDLE_PC, NOP, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0, 1'b1);
    plain_fetch(32'h8000_0200);
    idle_cycle();
    end_test();

    // Random gaps around req and ack
    start_test("handshake");
    for (int i = 0; i < 12; i++) begin
      probe_pc = 32'h8000_0000 | ($urandom & 32'h0000_03fc);
      train_btb(probe_pc, $urandom & 32'hffff_fffc, 1'b1, $urandom_range(3),
                $urandom_range(3));
      plain_fetch(probe_pc);
      idle_cycle();
    end
    end_test();

    // Let the last edges reach the bound assertions
    repeat (2) @(posedge i_clk);
    errors += i_branch_predict_top.i_props.assert_failures;
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- project.f
design/bp_pkg.sv
design/btb_write_if.sv
design/ras_ctrl_if.sv
design/btb_update_fsm.sv
design/btb_table.sv
design/ras_detector.sv
design/ras_pointer.sv
design/ras_stack.sv
design/prediction_select.sv
design/branch_predict_top.sv
tb/branch_predict_props.sv
tb/tb_branch_predict.sv

//--- Bender.yml
package:
  name: branch_predict

sources:
  # Package and interfaces first
  - design/bp_pkg.sv
  - design/btb_write_if.sv
  - design/ras_ctrl_if.sv
  # RTL
  - design/btb_update_fsm.sv
  - design/btb_table.sv
  - design/ras_detector.sv
  - design/ras_pointer.sv
  - design/ras_stack.sv
  - design/prediction_select.sv
  - design/branch_predict_top.sv
  # Testbench
  - target: test
    files:
      - tb/branch_predict_props.sv
      - tb/tb_branch_predict.sv
